//--- sources.f
mario_pkg.sv
landing_detect.sv
mario_fsm.sv
x_motion.sv
y_motion.sv
pose_select.sv
mario_top.sv
mario_sva.sv
tb_mario.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mario -f sources.f -o sim_mario

./obj_dir/sim_mario | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_mario.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mario
    import mario_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int WALK_MIN     = 4;
    localparam int WALK_SPAN    = 12;
    localparam int CLAMP_HOLD   = 100;
    localparam int LEFT_HOLD    = 2;
    localparam int JUMP_LIMIT   = 20;
    localparam int DEATH_HOLD   = 8;
    localparam logic [31:0] LCG_SEED = 32'h8024;
    // all tests back to back, with a wide margin
    localparam int RUN_CYCLES = 3 * RESET_CYCLES + WALK_MIN + WALK_SPAN + CLAMP_HOLD +
                                LEFT_HOLD + JUMP_LIMIT + DEATH_HOLD + 20;
    localparam int WATCHDOG_CYCLES = 10 * RUN_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic        over;
    logic        key_left;
    logic        key_right;
    logic        key_jump;
    xpos_t       x;
    ypos_t       y;
    move_state_t state;
    pose_t       pose;
    logic [31:0] rng;

    mario_top u_mario_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .over      (over),
        .key_left  (key_left),
        .key_right (key_right),
        .key_jump  (key_jump),
        .x         (x),
        .y         (y),
        .state     (state),
        .pose      (pose)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_xpos(input string test, input xpos_t exp, input xpos_t act);
        if (act !== exp) begin
            $display("Error %s: expected x %0d, got %0d", test, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "x mismatch");
        end
    endtask

    task automatic check_ypos(input string test, input ypos_t exp, input ypos_t act);
        if (act !== exp) begin
            $display("Error %s: expected y %0d, got %0d", test, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "y mismatch");
        end
    endtask

    task automatic check_state(input string test, input move_state_t exp,
                               input move_state_t act);
        if (act !== exp) begin
            $display("Error %s: expected state %s (%0d), got %s (%0d)",
                     test, exp.name(), exp, act.name(), act);
            $display("RESULT: FAIL");
            $fatal(1, "state mismatch");
        end
    endtask

    task automatic check_pose(input string test, input pose_t exp, input pose_t act);
        if (act !== exp) begin
            $display("Error %s: expected pose %s (%0d), got %s (%0d)",
                     test, exp.name(), exp, act.name(), act);
            $display("RESULT: FAIL");
            $fatal(1, "pose mismatch");
        end
    endtask

    // one frame; outputs are read and inputs driven at the falling edge
    task automatic tick();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // stride order 1, 3, 2, 3 over counter bits 2 to 1
    function automatic pose_t right_stride_pose(input int cnt);
        case ((cnt / 2) % 4)
            0: return POSE_WALK_RIGHT1;
            2: return POSE_WALK_RIGHT2;
            default: return POSE_WALK_RIGHT3;
        endcase
    endfunction

    // highest point of a jump from the floor, y moves by the old speed
    function automatic ypos_t jump_apex();
        int ypos;
        int speed;
        ypos  = int'(Y_FLOOR);
        speed = -int'(JUMP_SPEED);
        while (speed < 0) begin
            ypos  = ypos + speed;
            speed = speed + int'(GRAVITY);
        end
        return ypos_t'(ypos);
    endfunction

    task automatic reset_start_test();
        apply_reset();
        check_state("reset_start", ST_INITIAL, state);
        check_xpos("reset_start", START_X, x);
        check_ypos("reset_start", START_Y, y);
        check_pose("reset_start", POSE_WALK_RIGHT3, pose);
        start = 1'b1;
        tick();
        start = 1'b0;
        check_state("reset_start", ST_STANDING, state);
    endtask

    task automatic walk_right_test();
        int steps;
        rng   = lcg_next(rng);
        steps = WALK_MIN + int'(rng[23:16]) % WALK_SPAN;
        key_right = 1'b1;
        tick();
        check_state("walk_right", ST_WALKING, state);
        check_xpos("walk_right", START_X, x);
        for (int n = 1; n <= steps; n++) begin
            tick();
            check_state("walk_right", ST_WALKING, state);
            // first walking frame still moves by zero
            check_xpos("walk_right",
                       xpos_t'(int'(START_X) + int'(WALK_SPEED) * (n - 1)), x);
            check_pose("walk_right", right_stride_pose(n), pose);
        end
        key_right = 1'b0;
        tick();
        check_state("walk_right", ST_STANDING, state);
        check_xpos("walk_right", xpos_t'(int'(START_X) + int'(WALK_SPEED) * steps), x);
    endtask

    task automatic clamp_test();
        key_right = 1'b1;
        for (int i = 0; i < CLAMP_HOLD; i++) begin
            tick();
            check_state("clamp", ST_WALKING, state);
        end
        check_xpos("clamp", X_MAX, x);
        key_right = 1'b0;
        key_left  = 1'b1;
        tick();
        check_xpos("clamp", X_MAX, x);
        for (int k = 1; k <= LEFT_HOLD; k++) begin
            tick();
            check_xpos("clamp", xpos_t'(int'(X_MAX) - int'(WALK_SPEED) * k), x);
        end
        key_left = 1'b0;
        tick();
        check_state("clamp", ST_STANDING, state);
        check_xpos("clamp", xpos_t'(int'(X_MAX) - int'(WALK_SPEED) * (LEFT_HOLD + 1)), x);
        check_pose("clamp", POSE_WALK_LEFT3, pose);
    endtask

    task automatic jump_test();
        xpos_t ground_x;
        ypos_t min_y;
        int    cycles;
        ground_x = x;
        key_jump = 1'b1;
        tick();
        key_jump = 1'b0;
        check_state("jump", ST_JUMPING, state);
        tick();
        check_state("jump", ST_FLYING, state);
        check_ypos("jump", Y_FLOOR, y);
        // no horizontal speed, so the flight pose faces left
        check_pose("jump", POSE_FLY_LEFT, pose);
        min_y  = y;
        cycles = 0;
        while (state != ST_STANDING) begin
            if (cycles == JUMP_LIMIT) begin
                $display("jump: no landing within %0d cycles", JUMP_LIMIT);
                $display("RESULT: FAIL");
                $fatal(1, "landing timeout");
            end else begin
                tick();
                cycles++;
                if (y < min_y) begin
                    min_y = y;
                end
            end
        end
        check_ypos("jump", jump_apex(), min_y);
        check_ypos("jump", Y_FLOOR, y);
        check_xpos("jump", ground_x, x);
    endtask

    task automatic death_test();
        over = 1'b1;
        tick();
        over = 1'b0;
        check_state("death", ST_DYING, state);
        key_left  = 1'b1;
        key_right = 1'b1;
        key_jump  = 1'b1;
        repeat (DEATH_HOLD) begin
            tick();
            check_state("death", ST_DYING, state);
        end
        key_left  = 1'b0;
        key_right = 1'b0;
        key_jump  = 1'b0;
        apply_reset();
        check_state("death", ST_INITIAL, state);
        check_xpos("death", START_X, x);
        check_ypos("death", START_Y, y);
        check_pose("death", POSE_WALK_RIGHT3, pose);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        over      = 1'b0;
        key_left  = 1'b0;
        key_right = 1'b0;
        key_jump  = 1'b0;
        rng       = LCG_SEED;
        reset_start_test();
        walk_right_test();
        clamp_test();
        jump_test();
        death_test();
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: simulation hung after %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- mario_sva.sv
`timescale 1ns/100ps
`default_nettype none

module mario_sva
    import mario_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        over,
    input xpos_t       x,
    input move_state_t state
);

    // sprite stays inside the playfield
    x_in_screen: assert property (@(posedge clk) disable iff (rst)
        (x >= LEFT_BOUND) && (x <= X_MAX))
        else $error("x outside the screen range");

    // only reset leaves the dying state
    dying_held: assert property (@(posedge clk) disable iff (rst)
        (state == ST_DYING) |=> (state == ST_DYING))
        else $error("dying state left without reset");

    // jump impulse lasts a single frame
    jump_to_fly: assert property (@(posedge clk) disable iff (rst)
        (state == ST_JUMPING && !over) |=> (state == ST_FLYING))
        else $error("jumping not followed by flying");

endmodule

bind mario_top mario_sva u_mario_sva (
    .clk   (clk),
    .rst   (rst),
    .over  (over),
    .x     (x),
    .state (state)
);

`default_nettype wire

//--- mario_top.sv
`timescale 1ns/100ps
`default_nettype none

module mario_top
    import mario_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        over,
    input  logic        key_left,
    input  logic        key_right,
    input  logic        key_jump,
    output xpos_t       x,
    output ypos_t       y,
    output move_state_t state,
    output pose_t       pose
);

    logic    on_ground;
    logic    facing_left;
    xspeed_t speed_x;
    yspeed_t speed_y;

    mario_fsm u_mario_fsm (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .over      (over),
        .key_left  (key_left),
        .key_right (key_right),
        .key_jump  (key_jump),
        .on_ground (on_ground),
        .speed_y   (speed_y),
        .state     (state)
    );

    landing_detect u_landing_detect (
        .x         (x),
        .y         (y),
        .on_ground (on_ground)
    );

    // horizontal and vertical units run side by side
    x_motion u_x_motion (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .key_left    (key_left),
        .key_right   (key_right),
        .x           (x),
        .speed_x     (speed_x),
        .facing_left (facing_left)
    );

    y_motion u_y_motion (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .x       (x),
        .speed_x (speed_x),
        .y       (y),
        .speed_y (speed_y)
    );

    pose_select u_pose_select (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .speed_x     (speed_x),
        .facing_left (facing_left),
        .pose        (pose)
    );

endmodule

`default_nettype wire

//--- pose_select.sv
`timescale 1ns/100ps
`default_nettype none

module pose_select
    import mario_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  move_state_t state,
    input  xspeed_t     speed_x,
    input  logic        facing_left,
    output pose_t       pose
);

    logic [4:0] frame_cnt;

    // animation ticks only while moving
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (state == ST_WALKING || state == ST_FLYING) begin
            frame_cnt <= frame_cnt + 5'd1;
        end
    end

    always_comb begin
        case (state)
            ST_WALKING: begin
                // stride order 1, 3, 2, 3
                case (frame_cnt[2:1])
                    2'b00: pose = (speed_x > 0) ? POSE_WALK_RIGHT1 : POSE_WALK_LEFT1;
                    2'b01: pose = (speed_x > 0) ? POSE_WALK_RIGHT3 : POSE_WALK_LEFT3;
                    2'b10: pose = (speed_x > 0) ? POSE_WALK_RIGHT2 : POSE_WALK_LEFT2;
                    default: pose = (speed_x > 0) ? POSE_WALK_RIGHT3 : POSE_WALK_LEFT3;
                endcase
            end
            ST_FLYING: begin
                pose = (speed_x > 0) ? POSE_FLY_RIGHT : POSE_FLY_LEFT;
            end
            ST_DYING: begin
                case (frame_cnt[2:1])
                    2'b00: pose = POSE_DIE1;
                    2'b01: pose = POSE_DIE2;
                    2'b10: pose = POSE_DIE3;
                    default: pose = POSE_DIE4;
                endcase
            end
            default: begin
                pose = facing_left ? POSE_WALK_LEFT3 : POSE_WALK_RIGHT3;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- y_motion.sv
`timescale 1ns/100ps
`default_nettype none

module y_motion
    import mario_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  move_state_t state,
    input  xpos_t       x,
    input  xspeed_t     speed_x,
    output ypos_t       y,
    output yspeed_t     speed_y
);

    ycalc_t sy;
    xcalc_t sx;
    ycalc_t y_try;
    ycalc_t foot_try;
    xcalc_t xp_left;
    xcalc_t xp_right;
    logic   bump;
    logic   land;
    logic   over_plat;
    ypos_t  bump_y;
    ypos_t  land_y;
    ypos_t  fly_y;

    assign sy = speed_y;
    assign sx = speed_x;

    // predicted sprite box for this frame
    assign y_try    = wide_y(y) + sy;
    assign foot_try = y_try + wide_y(SPRITE_H);
    assign xp_left  = wide_x(x) + sx;
    assign xp_right = xp_left + wide_x(SPRITE_W);

    always_comb begin
        bump      = y_try < wide_y(TOP_BOUND);
        bump_y    = TOP_BOUND;
        land      = foot_try > wide_y(BOTTOM_BOUND);
        land_y    = Y_FLOOR;
        over_plat = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            over_plat = (xp_left < wide_x(PLAT_RX[i])) && (xp_right > wide_x(PLAT_LX[i]));
            // head inside the platform slab
            if (!bump && over_plat && y_try > wide_y(PLAT_TY[i]) &&
                y_try < wide_y(PLAT_BY[i])) begin
                bump   = 1'b1;
                bump_y = PLAT_BY[i];
            end
            // feet inside the platform slab
            if (!land && over_plat && foot_try > wide_y(PLAT_TY[i]) &&
                foot_try < wide_y(PLAT_BY[i])) begin
                land   = 1'b1;
                land_y = PLAT_TY[i] - SPRITE_H;
            end
        end
        // head bump takes priority over landing
        if (bump) begin
            fly_y = bump_y;
        end else if (land) begin
            fly_y = land_y;
        end else begin
            fly_y = y_try[8:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y       <= START_Y;
            speed_y <= '0;
        end else begin
            case (state)
                ST_INITIAL: begin
                    y       <= START_Y;
                    speed_y <= '0;
                end
                ST_JUMPING: begin
                    speed_y <= -JUMP_SPEED;
                end
                ST_FLYING: begin
                    y       <= fly_y;
                    speed_y <= speed_y + GRAVITY;
                end
                default: begin
                    speed_y <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- x_motion.sv
`timescale 1ns/100ps
`default_nettype none

module x_motion
    import mario_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  move_state_t state,
    input  logic        key_left,
    input  logic        key_right,
    output xpos_t       x,
    output xspeed_t     speed_x,
    output logic        facing_left
);

    xcalc_t sx;
    xcalc_t x_try;
    xpos_t  x_clamp;
    logic   clamped;

    assign sx = speed_x;

    // move by last frame's speed, then hold inside the screen
    always_comb begin
        x_try   = wide_x(x) + sx;
        clamped = 1'b1;
        if (x_try < wide_x(LEFT_BOUND)) begin
            x_clamp = LEFT_BOUND;
        end else if (x_try > wide_x(X_MAX)) begin
            x_clamp = X_MAX;
        end else begin
            x_clamp = x_try[9:0];
            clamped = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x           <= START_X;
            speed_x     <= '0;
            facing_left <= 1'b0;
        end else begin
            case (state)
                ST_INITIAL: begin
                    x       <= START_X;
                    speed_x <= '0;
                end
                ST_WALKING: begin
                    x <= x_clamp;
                    // left wins when both keys are held
                    if (key_left) begin
                        speed_x     <= -WALK_SPEED;
                        facing_left <= 1'b1;
                    end else if (key_right) begin
                        speed_x     <= WALK_SPEED;
                        facing_left <= 1'b0;
                    end
                end
                ST_FLYING: begin
                    x <= x_clamp;
                    if (clamped) begin
                        speed_x <= '0;
                    end
                end
                ST_STANDING, ST_DYING: begin
                    speed_x <= '0;
                end
                default: begin
                    x <= x;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mario_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mario_fsm
    import mario_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        over,
    input  logic        key_left,
    input  logic        key_right,
    input  logic        key_jump,
    input  logic        on_ground,
    input  yspeed_t     speed_y,
    output move_state_t state
);

    move_state_t next_state;
    logic        dir_key;

    assign dir_key = key_left || key_right;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_INITIAL;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_INITIAL: begin
                if (start) begin
                    next_state = ST_STANDING;
                end
            end
            // held until reset
            ST_DYING: begin
                next_state = ST_DYING;
            end
            default: begin
                if (over) begin
                    next_state = ST_DYING;
                end else begin
                    case (state)
                        ST_JUMPING: begin
                            next_state = ST_FLYING;
                        end
                        ST_FLYING: begin
                            // land only once moving down or at rest
                            if (on_ground && speed_y >= 0) begin
                                next_state = ST_STANDING;
                            end
                        end
                        ST_STANDING, ST_WALKING: begin
                            if (!on_ground) begin
                                next_state = ST_FLYING;
                            end else if (key_jump) begin
                                next_state = ST_JUMPING;
                            end else if (state == ST_STANDING && dir_key) begin
                                next_state = ST_WALKING;
                            end else if (state == ST_WALKING && !dir_key) begin
                                next_state = ST_STANDING;
                            end
                        end
                        default: begin
                            next_state = state;
                        end
                    endcase
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- landing_detect.sv
`timescale 1ns/100ps
`default_nettype none

module landing_detect
    import mario_pkg::*;
(
    input  xpos_t x,
    input  ypos_t y,
    output logic  on_ground
);

    logic [10:0]              x_right;
    logic [9:0]               feet;
    logic [NUM_PLATFORMS-1:0] on_plat;

    // sprite right edge and foot line
    assign x_right = x + SPRITE_W;
    assign feet    = y + SPRITE_H;

    always_comb begin
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            // horizontal overlap and feet inside the top band
            on_plat[i] = (x < PLAT_RX[i]) && (x_right > PLAT_LX[i]) &&
                         (feet >= PLAT_TY[i]) && (feet <= PLAT_BY[i]);
        end
    end

    assign on_ground = (feet >= BOTTOM_BOUND) || (|on_plat);

endmodule

`default_nettype wire

//--- mario_pkg.sv
`default_nettype none

package mario_pkg;

    typedef logic [9:0] xpos_t;
    typedef logic [8:0] ypos_t;
    typedef logic signed [9:0] xspeed_t;
    typedef logic signed [8:0] yspeed_t;

    // wide signed forms for position plus speed arithmetic
    typedef logic signed [11:0] xcalc_t;
    typedef logic signed [10:0] ycalc_t;

    typedef enum logic [2:0] {
        ST_INITIAL  = 3'd0,
        ST_FLYING   = 3'd1,
        ST_JUMPING  = 3'd2,
        ST_WALKING  = 3'd3,
        ST_STANDING = 3'd4,
        ST_DYING    = 3'd5
    } move_state_t;

    typedef enum logic [3:0] {
        POSE_WALK_LEFT1  = 4'd1,
        POSE_WALK_LEFT2  = 4'd2,
        POSE_WALK_LEFT3  = 4'd3,
        POSE_WALK_RIGHT1 = 4'd4,
        POSE_WALK_RIGHT2 = 4'd5,
        POSE_FLY_LEFT    = 4'd6,
        POSE_FLY_RIGHT   = 4'd7,
        POSE_DIE1        = 4'd10,
        POSE_DIE2        = 4'd11,
        POSE_DIE3        = 4'd12,
        POSE_DIE4        = 4'd13,
        POSE_WALK_RIGHT3 = 4'd14
    } pose_t;

    localparam ypos_t TOP_BOUND    = 9'd5;
    localparam ypos_t BOTTOM_BOUND = 9'd461;
    localparam xpos_t LEFT_BOUND   = 10'd5;
    localparam xpos_t RIGHT_BOUND  = 10'd640;

    localparam xpos_t SPRITE_W = 10'd34;
    localparam ypos_t SPRITE_H = 9'd36;

    // rightmost x and floor-standing y for the sprite
    localparam xpos_t X_MAX   = RIGHT_BOUND - SPRITE_W;
    localparam ypos_t Y_FLOOR = BOTTOM_BOUND - SPRITE_H;

    localparam xpos_t START_X = 10'd136;
    localparam ypos_t START_Y = 9'd425;

    localparam xspeed_t WALK_SPEED = 10'sd5;
    localparam yspeed_t JUMP_SPEED = 9'sd5;
    localparam yspeed_t GRAVITY    = 9'sd1;

    localparam int NUM_PLATFORMS = 7;

    // platform rectangles, top to bottom of the screen
    localparam xpos_t PLAT_LX [NUM_PLATFORMS] = '{250, 0, 48, 0, 48, 0, 0};
    localparam xpos_t PLAT_RX [NUM_PLATFORMS] = '{388, 593, 640, 592, 640, 592, 640};
    localparam ypos_t PLAT_TY [NUM_PLATFORMS] = '{53, 114, 169, 243, 315, 388, 461};
    localparam ypos_t PLAT_BY [NUM_PLATFORMS] = '{70, 133, 187, 261, 334, 406, 479};

    function automatic xcalc_t wide_x(input xpos_t v);
        return $signed({2'b00, v});
    endfunction

    function automatic ycalc_t wide_y(input ypos_t v);
        return $signed({2'b00, v});
    endfunction

endpackage

`default_nettype wire
